//--- rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_core.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv

//--- Makefile
# Verilator build and run for the RV32I core testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -Mdir $(OBJ_DIR)

run: compile
	out=$$(./$(OBJ_DIR)/Vtb_rv_core 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_rv_core.sv
// Testbench for the RV32I core
// Instruction ROM, data memory with wait states, store checks
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    logic   i_clk;
    logic   i_arst_n;
    logic   i_if_valid;
    logic   i_mem_valid;
    logic   o_store_req;
    logic   o_load_req;
    instr_t i_instr;
    word_t  i_data_in;
    word_t  o_pc_out;
    word_t  o_data_addr;
    word_t  o_data_out;

    instr_t rom [0:127];
    word_t  dmem [0:255];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     prog_len;
    int     wait_left;
    logic   load_busy;
    integer seed = 32'h594d;

    rv_core rv_core_i (.*);

    bind rv_core rv_core_asserts rv_core_asserts_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_mem_valid(i_mem_valid),
        .o_pc_out(o_pc_out), .o_data_addr(o_data_addr),
        .o_store_req(o_store_req), .o_load_req(o_load_req)
    );

    always #2 i_clk = ~i_clk;

    function automatic instr_t alu_reg(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction
    function automatic instr_t alu_imm(int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction
    function automatic instr_t load_word(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction
    function automatic instr_t store_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction
    function automatic instr_t branch(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction
    function automatic instr_t upper(int opc, int rd, int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction
    function automatic instr_t jal_to(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction
    function automatic instr_t jalr_to(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
    endfunction

    // Initial memory contents spread over the whole word index
    function automatic word_t fill_word(int idx);
        return word_t'(idx) * 32'h9E37_79B9 + 32'h0F1E_2D3C;
    endfunction

    task automatic emit(input instr_t ins);
        rom[prog_len] = ins;
        prog_len++;
    endtask
    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // Skipped slot that must never store
    task automatic emit_poison();
        emit(store_word(0, 0, 32'h200));
    endtask

    task automatic build_program();
        prog_len = 0;
        emit(alu_imm(0, 1, 0, 5));             // x1 = 5
        emit(alu_imm(0, 2, 1, 7));             // x2 = 12
        emit(alu_reg(32'h20, 0, 3, 2, 1));     // x3 = 7
        emit(store_word(3, 0, 0));
        emit(upper(32'h37, 4, 32'h12345));
        emit(alu_imm(0, 4, 4, 32'h678));
        emit(store_word(4, 0, 4));
        emit(upper(32'h17, 5, 1));             // at PC 0x1C
        emit(store_word(5, 0, 8));
        emit(alu_imm(0, 6, 0, -8));
        emit(alu_imm(5, 7, 6, 32'h401));       // srai by 1
        emit(alu_imm(5, 8, 6, 28));            // srli by 28
        emit(alu_reg(0, 4, 9, 7, 8));
        emit(store_word(9, 0, 12));
        emit(alu_reg(0, 2, 10, 6, 1));         // slt gives 1
        emit(alu_reg(0, 3, 11, 6, 1));         // sltu gives 0
        emit(alu_reg(0, 1, 12, 1, 10));        // 5 << 1
        emit(alu_reg(0, 6, 13, 12, 11));
        emit(alu_reg(0, 7, 14, 13, 3));        // 10 & 7
        emit(alu_reg(0, 0, 15, 14, 10));
        emit(store_word(15, 0, 16));
        emit(store_word(11, 0, 20));
        emit(load_word(16, 0, 32'h80));
        emit(alu_imm(0, 17, 16, 32'h11));
        emit(store_word(17, 0, 24));
        emit(load_word(18, 0, 4));
        emit(alu_reg(0, 0, 19, 18, 18));
        emit(store_word(19, 0, 28));
        emit(load_word(20, 0, 0));
        emit(store_word(20, 0, 32));
        // One taken branch of each kind
        emit(branch(0, 1, 1, 8));
        emit_poison();
        emit(branch(1, 1, 3, 8));
        emit_poison();
        emit(branch(4, 6, 1, 8));
        emit_poison();
        emit(branch(5, 1, 6, 8));
        emit_poison();
        emit(branch(6, 1, 6, 8));
        emit_poison();
        emit(branch(7, 6, 1, 8));
        emit_poison();
        // Not-taken branches each followed by a store that must appear
        emit(branch(0, 1, 3, 8));
        emit(store_word(1, 0, 36));
        emit(branch(1, 1, 1, 8));
        emit(store_word(3, 0, 40));
        emit(branch(4, 1, 6, 8));
        emit(store_word(10, 0, 44));
        emit(branch(5, 6, 1, 8));
        emit(store_word(1, 0, 48));
        emit(branch(6, 6, 1, 8));
        emit(store_word(3, 0, 52));
        emit(branch(7, 1, 6, 8));
        emit(store_word(10, 0, 56));
        emit(jal_to(21, 12));
        emit_poison();
        emit_poison();
        emit(store_word(21, 0, 60));
        emit(alu_imm(0, 22, 0, 32'hF9));
        emit(jalr_to(23, 22, 0));
        emit_poison();
        emit_poison();
        emit(store_word(23, 0, 64));
        emit(alu_imm(0, 0, 1, 123));
        emit(store_word(0, 0, 68));
        emit(store_word(1, 0, 32'hFC));
    endtask

    task automatic build_expectations();
        expect_store(32'h00, 32'd7);
        expect_store(32'h04, 32'h1234_5678);
        expect_store(32'h08, 32'h0000_101C);    // 0x1C + 0x1000
        expect_store(32'h0C, 32'hFFFF_FFF3);    // 0xFFFFFFFC ^ 0xF
        expect_store(32'h10, 32'd3);
        expect_store(32'h14, 32'd0);
        expect_store(32'h18, fill_word(32) + 32'h11);
        expect_store(32'h1C, 32'h2468_ACF0);
        expect_store(32'h20, 32'd7);
        expect_store(32'h24, 32'd5);
        expect_store(32'h28, 32'd7);
        expect_store(32'h2C, 32'd1);
        expect_store(32'h30, 32'd5);
        expect_store(32'h34, 32'd7);
        expect_store(32'h38, 32'd1);
        expect_store(32'h3C, 32'h0000_00DC);    // link of JAL at 0xD8
        expect_store(32'h40, 32'h0000_00F0);    // link of JALR at 0xEC
        expect_store(32'h44, 32'd0);
        expect_store(32'hFC, 32'd5);
    endtask

    initial begin
        i_clk = 1'b0;
        i_arst_n = 1'b0;
        i_if_valid = 1'b0;
        i_mem_valid = 1'b0;
        i_instr = `RV_NOP;
        i_data_in = '0;
        load_busy = 1'b0;
        wait_left = 0;
        for (int i = 0; i < 128; i++) begin
            rom[i] = `RV_NOP;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        build_program();
        build_expectations();
        repeat (10) @(posedge i_clk);
        #1;
        assert (o_pc_out == `RV_PC_START) else begin
            $display("CHECK FAILED o_pc_out: got %h expected %h", o_pc_out, `RV_PC_START);
            abort_run("Reset PC check failed");
        end
        assert (!o_store_req) else begin
            $display("CHECK FAILED o_store_req: got %h expected %h", o_store_req, 1'b0);
            abort_run("Store request active during reset");
        end
        assert (!o_load_req) else begin
            $display("CHECK FAILED o_load_req: got %h expected %h", o_load_req, 1'b0);
            abort_run("Load request active during reset");
        end
        i_arst_n = 1'b1;
    end

    // Watchdog scaled by program length
    initial begin
        @(posedge i_arst_n);
        #((prog_len * 20 + 10) * 4);
        abort_run("Watchdog timeout: the final store never appeared");
    end

    // Instruction fetch, fetch stalls and data memory answers
    always @(posedge i_clk) begin
        #1;
        i_instr = rom[o_pc_out[8:2]];
        i_if_valid = ($random(seed) % 5) != 0;
        if (o_load_req) begin
            if (!load_busy) begin
                load_busy = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                i_mem_valid = 1'b1;
                i_data_in = dmem[o_data_addr[9:2]];
                load_busy = 1'b0;
            end else begin
                i_mem_valid = 1'b0;
                wait_left--;
            end
        end else begin
            i_mem_valid = 1'b0;
            load_busy = 1'b0;
        end
    end

    // Compare every store with the head of the expected list
    always @(negedge i_clk) begin
        if (i_arst_n && o_store_req) begin
            assert (o_data_addr == exp_addr[0]) else begin
                $display("CHECK FAILED o_data_addr: got %h expected %h",
                         o_data_addr, exp_addr[0]);
                abort_run("Store address mismatch");
            end
            assert (o_data_out == exp_data[0]) else begin
                $display("CHECK FAILED o_data_out: got %h expected %h",
                         o_data_out, exp_data[0]);
                abort_run("Store data mismatch");
            end
            dmem[o_data_addr[9:2]] = o_data_out;
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            // The store to 0xFC is the last entry
            if (exp_addr.size() == 0) begin
                $display("Result: PASSED");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/rv_core_asserts.sv
// Port protocol assertions for the RV32I core
// Request exclusivity, reset state, alignment and load hold
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
    input logic               i_clk,
    input logic               i_arst_n,
    input logic               i_mem_valid,
    input rv_core_pkg::word_t o_pc_out,
    input rv_core_pkg::word_t o_data_addr,
    input logic               o_store_req,
    input logic               o_load_req
);
    import rv_core_pkg::*;

    a_req_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_store_req && o_load_req))
        else $error("store and load requests high together");

    a_reset_idle: assert property (@(posedge i_clk)
        !i_arst_n |-> (!o_store_req && !o_load_req))
        else $error("request high during reset");

    a_addr_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_store_req || o_load_req) |-> (o_data_addr[1:0] == 2'b00))
        else $error("data address not word aligned");

    // Load holds until the memory answers
    a_load_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_load_req && !i_mem_valid) |=> (o_load_req && $stable(o_data_addr)))
        else $error("load request dropped or moved before i_mem_valid");

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pc_out[1:0] == 2'b00)
        else $error("PC not word aligned");

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
// Four-stage RV32I core top level
// PC, pipeline registers, forwarding, load-use hazard and flush control
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_core (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_if_valid,
    input  logic                i_mem_valid,
    input  rv_core_pkg::instr_t i_instr,
    input  rv_core_pkg::word_t  i_data_in,
    output rv_core_pkg::word_t  o_pc_out,
    output rv_core_pkg::word_t  o_data_addr,
    output rv_core_pkg::word_t  o_data_out,
    output logic                o_store_req,
    output logic                o_load_req
);
    import rv_core_pkg::*;

    // Fetch and decode
    word_t     pc;
    instr_t    instr_d;
    word_t     pc_d;
    reg_addr_t d_rs1;
    reg_addr_t d_rs2;
    reg_addr_t d_rd;
    word_t     d_imm;
    alu_op_t   d_alu_op;
    logic      d_sel_pc_a;
    logic      d_sel_imm_b;
    logic      d_mem_w;
    logic      d_reg_w;
    logic      d_mem2reg;
    logic      d_bra;
    logic      d_jmp;
    reg_addr_t rf_rs1_addr;
    reg_addr_t rf_rs2_addr;
    word_t     rf_rs1;
    word_t     rf_rs2;
    word_t     d_rs1_val;
    word_t     d_rs2_val;

    // Execute
    logic      ex_reg_w;
    logic      ex_mem_w;
    logic      ex_mem2reg;
    logic      ex_bra;
    logic      ex_jmp;
    alu_op_t   ex_alu_op;
    logic      ex_sel_pc_a;
    logic      ex_sel_imm_b;
    logic      ex_jalr;
    word_t     ex_pc;
    word_t     ex_imm;
    word_t     ex_rs1;
    word_t     ex_rs2;
    reg_addr_t ex_rs1_addr;
    reg_addr_t ex_rs2_addr;
    reg_addr_t ex_rd;
    word_t     ex_rs1_fwd;
    word_t     ex_rs2_fwd;
    word_t     ex_alu_out;
    logic      ex_taken;
    word_t     ex_target;

    // Memory and writeback
    logic      mem_reg_w;
    logic      mem_mem_w;
    logic      mem_mem2reg;
    word_t     mem_alu;
    word_t     mem_rs2;
    reg_addr_t mem_rd;
    logic      wb_reg_w;
    logic      wb_mem2reg;
    word_t     wb_alu;
    word_t     wb_load;
    reg_addr_t wb_rd;
    word_t     wb_result;

    // Hazard control
    logic      load_wait;
    logic      load_hazard;
    logic      redirect;
    logic      stall_d;
    logic      fetch_take;

    assign d_rs1 = instr_d[19:15];
    assign d_rs2 = instr_d[24:20];
    assign d_rd  = instr_d[11:7];

    assign load_wait   = o_load_req && !i_mem_valid;
    assign load_hazard = ex_mem2reg && ex_reg_w && (ex_rd == d_rs1 || ex_rd == d_rs2);
    assign redirect    = ((ex_bra && ex_taken) || ex_jmp) && !load_wait;
    assign stall_d     = load_wait || load_hazard;
    assign fetch_take  = i_if_valid && !stall_d && !redirect;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= `RV_PC_START;
            instr_d <= `RV_NOP;
        end else if (redirect) begin
            pc      <= ex_target;
            instr_d <= `RV_NOP;
        end else if (fetch_take) begin
            pc      <= pc + word_t'(4);
            instr_d <= i_instr;
        end else if (!stall_d) begin
            instr_d <= `RV_NOP;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch_take) begin
            pc_d <= pc;
        end
    end

    rv_decode u_decode (
        .i_instr     (instr_d),
        .o_imm       (d_imm),
        .o_alu_op    (d_alu_op),
        .o_sel_pc_a  (d_sel_pc_a),
        .o_sel_imm_b (d_sel_imm_b),
        .o_mem_w     (d_mem_w),
        .o_reg_w     (d_reg_w),
        .o_mem2reg   (d_mem2reg),
        .o_bra       (d_bra),
        .o_jmp       (d_jmp)
    );

    // Read for whichever instruction sits in decode next cycle
    assign rf_rs1_addr = fetch_take ? i_instr[19:15] : d_rs1;
    assign rf_rs2_addr = fetch_take ? i_instr[24:20] : d_rs2;

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_wr_en    (wb_reg_w),
        .i_rs1_addr (rf_rs1_addr),
        .i_rs2_addr (rf_rs2_addr),
        .i_rd_addr  (wb_rd),
        .i_rd_data  (wb_result),
        .o_rs1_data (rf_rs1),
        .o_rs2_data (rf_rs2)
    );

    // Writeback lands after the read was taken
    assign d_rs1_val = (wb_reg_w && wb_rd == d_rs1) ? wb_result : rf_rs1;
    assign d_rs2_val = (wb_reg_w && wb_rd == d_rs2) ? wb_result : rf_rs2;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_reg_w   <= 1'b0;
            ex_mem_w   <= 1'b0;
            ex_mem2reg <= 1'b0;
            ex_bra     <= 1'b0;
            ex_jmp     <= 1'b0;
        end else if (!load_wait) begin
            // Bubble on flush or load-use
            ex_reg_w   <= d_reg_w && (d_rd != '0) && !redirect && !load_hazard;
            ex_mem_w   <= d_mem_w && !redirect && !load_hazard;
            ex_mem2reg <= d_mem2reg && !redirect && !load_hazard;
            ex_bra     <= d_bra && !redirect && !load_hazard;
            ex_jmp     <= d_jmp && !redirect && !load_hazard;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_wait) begin
            // Keep operands current while writeback drains
            ex_rs1 <= ex_rs1_fwd;
            ex_rs2 <= ex_rs2_fwd;
        end else begin
            ex_rs1       <= d_rs1_val;
            ex_rs2       <= d_rs2_val;
            ex_alu_op    <= d_alu_op;
            ex_sel_pc_a  <= d_sel_pc_a;
            ex_sel_imm_b <= d_sel_imm_b;
            ex_jalr      <= d_jmp && !instr_d[3];
            ex_pc        <= pc_d;
            ex_imm       <= d_imm;
            ex_rs1_addr  <= d_rs1;
            ex_rs2_addr  <= d_rs2;
            ex_rd        <= d_rd;
        end
    end

    // Memory stage has priority over writeback
    assign ex_rs1_fwd = (mem_reg_w && mem_rd == ex_rs1_addr) ? mem_alu :
                        (wb_reg_w && wb_rd == ex_rs1_addr)   ? wb_result : ex_rs1;
    assign ex_rs2_fwd = (mem_reg_w && mem_rd == ex_rs2_addr) ? mem_alu :
                        (wb_reg_w && wb_rd == ex_rs2_addr)   ? wb_result : ex_rs2;

    rv_execute u_execute (
        .i_alu_op    (ex_alu_op),
        .i_sel_pc_a  (ex_sel_pc_a),
        .i_sel_imm_b (ex_sel_imm_b),
        .i_jalr      (ex_jalr),
        .i_rs1       (ex_rs1_fwd),
        .i_rs2       (ex_rs2_fwd),
        .i_pc        (ex_pc),
        .i_imm       (ex_imm),
        .o_alu_out   (ex_alu_out),
        .o_taken     (ex_taken),
        .o_target    (ex_target)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_reg_w   <= 1'b0;
            mem_mem_w   <= 1'b0;
            mem_mem2reg <= 1'b0;
            wb_reg_w    <= 1'b0;
            wb_mem2reg  <= 1'b0;
        end else if (load_wait) begin
            wb_reg_w   <= 1'b0;
            wb_mem2reg <= 1'b0;
        end else begin
            mem_reg_w   <= ex_reg_w;
            mem_mem_w   <= ex_mem_w;
            mem_mem2reg <= ex_mem2reg;
            wb_reg_w    <= mem_reg_w;
            wb_mem2reg  <= mem_mem2reg;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!load_wait) begin
            mem_alu <= ex_alu_out;
            mem_rs2 <= ex_rs2_fwd;
            mem_rd  <= ex_rd;
        end
        wb_alu  <= mem_alu;
        wb_rd   <= mem_rd;
        wb_load <= i_data_in;
    end

    assign wb_result = wb_mem2reg ? wb_load : wb_alu;

    assign o_pc_out    = pc;
    assign o_data_addr = mem_alu;
    assign o_data_out  = mem_rs2;
    assign o_store_req = mem_mem_w;
    assign o_load_req  = mem_mem2reg;

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
// Execute stage datapath
// ALU, branch condition and jump target adder
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_core_pkg::alu_op_t i_alu_op,
    input  logic                 i_sel_pc_a,
    input  logic                 i_sel_imm_b,
    input  logic                 i_jalr,
    input  rv_core_pkg::word_t   i_rs1,
    input  rv_core_pkg::word_t   i_rs2,
    input  rv_core_pkg::word_t   i_pc,
    input  rv_core_pkg::word_t   i_imm,
    output rv_core_pkg::word_t   o_alu_out,
    output logic                 o_taken,
    output rv_core_pkg::word_t   o_target
);
    import rv_core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t target_sum;
    logic  eq;
    logic  lt;
    logic  ltu;

    assign op_a = i_sel_pc_a ? i_pc : i_rs1;

    // PC without immediate only happens for jumps
    // B is then the link offset
    assign op_b = i_sel_imm_b ? i_imm : (i_sel_pc_a ? word_t'(4) : i_rs2);

    assign eq  = (op_a == op_b);
    assign lt  = ($signed(op_a) < $signed(op_b));
    assign ltu = (op_a < op_b);

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    o_alu_out = op_a + op_b;
            ALU_SUB:    o_alu_out = op_a - op_b;
            ALU_AND:    o_alu_out = op_a & op_b;
            ALU_OR:     o_alu_out = op_a | op_b;
            ALU_XOR:    o_alu_out = op_a ^ op_b;
            ALU_SLT:    o_alu_out = word_t'(lt);
            ALU_SLTU:   o_alu_out = word_t'(ltu);
            ALU_SLL:    o_alu_out = op_a << op_b[4:0];
            ALU_SRL:    o_alu_out = op_a >> op_b[4:0];
            ALU_SRA:    o_alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_PASS_B: o_alu_out = op_b;
            ALU_BEQ:    o_alu_out = word_t'(eq);
            ALU_BNE:    o_alu_out = word_t'(!eq);
            ALU_BGE:    o_alu_out = word_t'(!lt);
            ALU_BGEU:   o_alu_out = word_t'(!ltu);
            default:    o_alu_out = op_a + op_b;
        endcase
    end

    // Condition bit of compare ops
    // The core only acts on it for branches
    always_comb begin
        case (i_alu_op)
            ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE, ALU_BGE, ALU_BGEU: begin
                o_taken = o_alu_out[0];
            end
            default: begin
                o_taken = 1'b0;
            end
        endcase
    end

    // JALR clears bit 0 of the sum
    assign target_sum = (i_jalr ? i_rs1 : i_pc) + i_imm;
    assign o_target   = target_sum & ~word_t'(i_jalr);

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
// 32-entry integer register file
// Synchronous write-first reads, x0 reads as zero
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                   i_clk,
    input  logic                   i_wr_en,
    input  rv_core_pkg::reg_addr_t i_rs1_addr,
    input  rv_core_pkg::reg_addr_t i_rs2_addr,
    input  rv_core_pkg::reg_addr_t i_rd_addr,
    input  rv_core_pkg::word_t     i_rd_data,
    output rv_core_pkg::word_t     o_rs1_data,
    output rv_core_pkg::word_t     o_rs2_data
);
    import rv_core_pkg::*;

    // x1 to x31
    word_t regs [1:31];

    // Same-edge write wins over the stored value
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wr_en && addr == i_rd_addr) begin
            return i_rd_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_wr_en && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rs1_data <= read_port(i_rs1_addr);
        o_rs2_data <= read_port(i_rs2_addr);
    end

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
// Instruction decoder for the RV32I subset
// Control lines, ALU operation and immediate generation
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  rv_core_pkg::instr_t  i_instr,
    output rv_core_pkg::word_t   o_imm,
    output rv_core_pkg::alu_op_t o_alu_op,
    output logic                 o_sel_pc_a,
    output logic                 o_sel_imm_b,
    output logic                 o_mem_w,
    output logic                 o_reg_w,
    output logic                 o_mem2reg,
    output logic                 o_bra,
    output logic                 o_jmp
);
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    arith_op;
    alu_op_t    branch_op;
    logic       branch_ok;

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];

    // Sign-extended immediates for each format
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // Register and immediate arithmetic
    // funct7 only picks SUB for register ops
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (funct7_b5 && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // Branch compares
    always_comb begin
        branch_ok = 1'b1;
        case (funct3)
            3'b000:  branch_op = ALU_BEQ;
            3'b001:  branch_op = ALU_BNE;
            3'b100:  branch_op = ALU_SLT;
            3'b101:  branch_op = ALU_BGE;
            3'b110:  branch_op = ALU_SLTU;
            3'b111:  branch_op = ALU_BGEU;
            default: begin
                branch_op = ALU_BEQ;
                branch_ok = 1'b0;
            end
        endcase
    end

    // Jumps select the PC without an immediate to form the link value
    always_comb begin
        o_imm       = '0;
        o_alu_op    = ALU_ADD;
        o_sel_pc_a  = 1'b0;
        o_sel_imm_b = 1'b0;
        o_mem_w     = 1'b0;
        o_reg_w     = 1'b0;
        o_mem2reg   = 1'b0;
        o_bra       = 1'b0;
        o_jmp       = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_alu_op = arith_op;
                o_reg_w  = 1'b1;
            end
            OPC_OP_IMM: begin
                o_imm       = imm_i;
                o_alu_op    = arith_op;
                o_sel_imm_b = 1'b1;
                o_reg_w     = 1'b1;
            end
            OPC_LUI: begin
                o_imm       = imm_u;
                o_alu_op    = ALU_PASS_B;
                o_sel_imm_b = 1'b1;
                o_reg_w     = 1'b1;
            end
            OPC_AUIPC: begin
                o_imm       = imm_u;
                o_sel_pc_a  = 1'b1;
                o_sel_imm_b = 1'b1;
                o_reg_w     = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                o_imm      = (opcode == OPC_JAL) ? imm_j : imm_i;
                o_sel_pc_a = 1'b1;
                o_reg_w    = 1'b1;
                o_jmp      = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm    = imm_b;
                o_alu_op = branch_op;
                o_bra    = branch_ok;
            end
            OPC_LOAD: begin
                o_imm       = imm_i;
                o_sel_imm_b = 1'b1;
                o_reg_w     = 1'b1;
                o_mem2reg   = 1'b1;
            end
            OPC_STORE: begin
                o_imm       = imm_s;
                o_sel_imm_b = 1'b1;
                o_mem_w     = 1'b1;
            end
            default: begin
                o_alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_core_pkg.sv
// Shared types of the RV32I core
// Data words, instructions, register indices and ALU operation codes
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

    // Register values, addresses and the PC
    typedef logic [`RV_XLEN-1:0] word_t;

    typedef logic [31:0] instr_t;

    typedef logic [4:0] reg_addr_t;

    // ALU operations
    // BLT and BLTU reuse the SLT and SLTU compares
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10,
        ALU_BEQ    = 4'd11,
        ALU_BNE    = 4'd12,
        ALU_BGE    = 4'd13,
        ALU_BGEU   = 4'd14
    } alu_op_t;

endpackage

`default_nettype wire

//--- rtl/rv_core_defs.svh
// Core-wide constants for the RV32I pipeline
// Data width, reset PC and the NOP encoding

`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data path width
`define RV_XLEN 32

// First fetch address after reset
`define RV_PC_START 32'h0000_0000

// ADDI x0, x0, 0
// Loaded into decode when it is flushed
`define RV_NOP 32'h0000_0013

`endif
